//--- thor_pkg.sv
package thor_pkg;

  // ==============================
  // Widths that carry a meaning
  // ==============================

  // A single instruction byte
  typedef logic [7:0]  byte_t;

  // One fetch word as delivered by the fetch source, byte 0 in the low bits
  typedef logic [63:0] fetch_word_t;

  // Instruction window of eight bytes with the opcode in byte 0
  typedef logic [63:0] ins_t;

  // Instruction length in bytes, the decoder only ever returns 2, 4, 6 or 8
  typedef logic [3:0]  ilen_t;

  // Program counter
  typedef logic [31:0] addr_t;

  // Byte count of the fetch buffer, wide enough for a 32 byte buffer
  typedef logic [5:0]  bcnt_t;

  // The longest instruction in bytes
  localparam int MAX_ILEN    = 8;

  // Bytes carried by one fetch word
  localparam int FETCH_BYTES = 8;

  // ==============================
  // Opcodes
  // ==============================

  // Control and basic arithmetic
  localparam byte_t BRK   = 8'h00;
  localparam byte_t R2    = 8'h02;
  localparam byte_t ADDI  = 8'h04;
  localparam byte_t ADDIL = 8'h05;

  // Jumps
  localparam byte_t JMP   = 8'h20;
  localparam byte_t JEQZ  = 8'h22;

  // Immediate extension prefixes
  // Only the even value of each pair lives here, the odd one is base+1
  localparam byte_t EXI8  = 8'h50;
  localparam byte_t EXI24 = 8'h52;
  localparam byte_t EXI40 = 8'h54;
  localparam byte_t EXI56 = 8'h56;
  localparam byte_t EXIM  = 8'h58;

  // Loads and stores
  localparam byte_t LDO   = 8'h60;
  localparam byte_t LDOX  = 8'h68;
  localparam byte_t STO   = 8'h70;

  // Short forms in the top row
  localparam byte_t NOP   = 8'hF1;
  localparam byte_t RTS   = 8'hF2;
  localparam byte_t ENTER = 8'hF4;

endpackage

//--- thor_inslength.sv
`timescale 1ns/1ns

// Length decoder for the instruction at the head of the fetch buffer.
// Purely combinational, the length comes from the opcode byte alone
module thor_inslength import thor_pkg::*; (
  input  ins_t  ir,
  output ilen_t len
);

  // Opcode is always the first byte of the window
  byte_t opcode;

  assign opcode = ir[7:0];

  // ==============================
  // Opcode to length table
  // ==============================

  always_comb begin
    casez (opcode)
      // Breakpoint is a two byte form
      BRK:       len = 4'd2;

      // Register and immediate forms
      R2:        len = 4'd6;
      ADDI:      len = 4'd4;
      ADDIL:     len = 4'd6;

      // Jumps, the conditional one carries a short displacement
      JMP:       len = 4'd6;
      JEQZ:      len = 4'd4;

      // Each immediate extension comes as an even/odd pair of the same length
      EXI8:      len = 4'd2;
      EXI8 + 1:  len = 4'd2;
      EXI24:     len = 4'd4;
      EXI24 + 1: len = 4'd4;
      EXI40:     len = 4'd6;
      EXI40 + 1: len = 4'd6;
      EXI56:     len = 4'd8;
      EXI56 + 1: len = 4'd8;

      // The multi-word extension fills the whole window
      EXIM:      len = 4'd8;

      // Displacement loads and stores are long, the indexed load is short
      LDO:       len = 4'd6;
      LDOX:      len = 4'd4;
      STO:       len = 4'd6;

      // The whole D row is one family of six byte instructions
      8'hD?:     len = 4'd6;

      // Single byte style operations padded to two bytes
      NOP:       len = 4'd2;
      RTS:       len = 4'd2;

      // Stack frame setup carries a frame size
      ENTER:     len = 4'd4;

      // Anything not listed is treated as the shortest form
      default:   len = 4'd2;
    endcase
  end

endmodule

//--- thor_fetch_buffer.sv
`timescale 1ns/1ns

// Byte queue between the fetch source and the aligner.
// Oldest byte sits at index 0, new words are appended behind what remains
module thor_fetch_buffer import thor_pkg::*; #(
  parameter int BUF_BYTES = 16
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        fetch_valid,
  input  fetch_word_t fetch_data,
  input  logic        flush,
  input  logic        pop,
  input  ilen_t       pop_len,
  output ins_t        head,
  output bcnt_t       count,
  output logic        room,
  output logic        overflow
);

  // Byte storage and its next value
  byte_t buf_q [BUF_BYTES];
  byte_t buf_d [BUF_BYTES];

  // Incoming fetch word split into bytes
  byte_t fw_bytes [FETCH_BYTES];

  bcnt_t count_q;
  bcnt_t count_d;
  bcnt_t pop_n;
  bcnt_t remain;
  logic  push;

  // ==============================
  // Flow control
  // ==============================

  // Room is judged on the count before any pop of this cycle
  assign room = (count_q <= bcnt_t'(BUF_BYTES - FETCH_BYTES));

  // A flush throws away a word strobed in the same cycle
  assign push = fetch_valid & room & ~flush;

  // Bytes leaving the head this cycle and the bytes that stay behind
  assign pop_n  = pop ? bcnt_t'(pop_len) : '0;
  assign remain = count_q - pop_n;

  always_comb begin
    for (int j = 0; j < FETCH_BYTES; j++) begin
      fw_bytes[j] = fetch_data[j*8 +: 8];
    end
  end

  // ==============================
  // Shift and append
  // ==============================

  always_comb begin
    for (int i = 0; i < BUF_BYTES; i++) begin
      // Shift the surviving bytes down to the front
      if (i + int'(pop_n) < BUF_BYTES) begin
        buf_d[i] = buf_q[i + int'(pop_n)];
      end else begin
        buf_d[i] = buf_q[i];
      end
      // The new word lands right behind the last surviving byte
      if (push && (i >= int'(remain)) && (i < int'(remain) + FETCH_BYTES)) begin
        buf_d[i] = fw_bytes[3'(i - int'(remain))];
      end
    end
  end

  always_comb begin
    if (flush) begin
      count_d = '0;
    end else if (push) begin
      count_d = remain + bcnt_t'(FETCH_BYTES);
    end else begin
      count_d = remain;
    end
  end

  // Storage has no reset, bytes at or above count are never looked at
  always_ff @(posedge clk) begin
    buf_q <= buf_d;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count_q  <= '0;
      overflow <= 1'b0;
    end else begin
      count_q <= count_d;
      // Sticky flag for a source that ignored room
      if (fetch_valid && !room) begin
        overflow <= 1'b1;
      end
    end
  end

  // ==============================
  // Head window
  // ==============================

  // The aligner sees the oldest MAX_ILEN bytes as one instruction window
  always_comb begin
    for (int k = 0; k < MAX_ILEN; k++) begin
      head[k*8 +: 8] = buf_q[k];
    end
  end

  assign count = count_q;

endmodule

//--- thor_ins_align.sv
`timescale 1ns/1ns

// Aligner at the head of the fetch buffer.
// Issues one whole instruction per cycle at most and tracks its program counter
module thor_ins_align import thor_pkg::*; #(
  parameter addr_t RESET_PC = 32'h0000_1000
) (
  input  logic  clk,
  input  logic  arst_n,
  input  ins_t  head,
  input  bcnt_t count,
  input  logic  redirect,
  input  addr_t redirect_pc,
  output logic  pop,
  output ilen_t pop_len,
  output logic  ins_valid,
  output ins_t  ins,
  output ilen_t ins_len,
  output addr_t ins_pc
);

  // Length of the instruction currently at the head
  ilen_t dec_len;

  // Address of the byte at the head of the buffer
  addr_t pc_q;

  thor_inslength u_inslength (
    .ir  (head),
    .len (dec_len)
  );

  // ==============================
  // Issue decision
  // ==============================

  // Pop once every byte of the head instruction is present.
  // A redirect wins and nothing leaves the buffer in its cycle
  assign pop     = ~redirect & (count != '0) & (count >= bcnt_t'(dec_len));
  assign pop_len = dec_len;

  // ==============================
  // Program counter and issue strobe
  // ==============================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q      <= RESET_PC;
      ins_valid <= 1'b0;
    end else begin
      ins_valid <= pop;
      if (redirect) begin
        pc_q <= redirect_pc;
      end else if (pop) begin
        // Instructions are contiguous so the next one starts right after
        pc_q <= pc_q + addr_t'(dec_len);
      end
    end
  end

  // Issued payload, captured on the same edge that removes the bytes
  always_ff @(posedge clk) begin
    if (pop) begin
      ins     <= head;
      ins_len <= dec_len;
      ins_pc  <= pc_q;
    end
  end

endmodule

//--- thor_ifetch_top.sv
`timescale 1ns/1ns

// Instruction aligner subsystem, fetch buffer feeding the head aligner
module thor_ifetch_top import thor_pkg::*; #(
  parameter int    BUF_BYTES = 16,
  parameter addr_t RESET_PC  = 32'h0000_1000
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        fetch_valid,
  input  fetch_word_t fetch_data,
  output logic        room,
  input  logic        redirect,
  input  addr_t       redirect_pc,
  output logic        overflow,
  output logic        ins_valid,
  output ins_t        ins,
  output ilen_t       ins_len,
  output addr_t       ins_pc
);

  // Buffer to aligner
  ins_t  head;
  bcnt_t count;

  // Aligner back to buffer
  logic  pop;
  ilen_t pop_len;

  // ==============================
  // Byte buffer
  // ==============================

  // A redirect also empties the buffer
  thor_fetch_buffer #(
    .BUF_BYTES (BUF_BYTES)
  ) u_fetch_buffer (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_data  (fetch_data),
    .flush       (redirect),
    .pop         (pop),
    .pop_len     (pop_len),
    .head        (head),
    .count       (count),
    .room        (room),
    .overflow    (overflow)
  );

  // ==============================
  // Aligner
  // ==============================

  thor_ins_align #(
    .RESET_PC (RESET_PC)
  ) u_ins_align (
    .clk         (clk),
    .arst_n      (arst_n),
    .head        (head),
    .count       (count),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pop         (pop),
    .pop_len     (pop_len),
    .ins_valid   (ins_valid),
    .ins         (ins),
    .ins_len     (ins_len),
    .ins_pc      (ins_pc)
  );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ns

// Free running 10 ns clock and an active low reset held for the first cycles
module tb_clkgen #(
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    // Flops still see reset on this edge, release takes effect right after it
    arst_n <= 1'b1;
  end

  always #5 clk = ~clk;

endmodule

//--- thor_ifetch_props.sv
`timescale 1ns/1ns

// Output checks on the aligner subsystem, bound into the top level
module thor_ifetch_props import thor_pkg::*; (
  input logic  clk,
  input logic  arst_n,
  input logic  redirect,
  input logic  overflow,
  input logic  ins_valid,
  input ilen_t ins_len
);

  // An issued instruction always has one of the four legal sizes
  a_len_legal: assert property (@(posedge clk) disable iff (!arst_n)
    ins_valid |-> (ins_len inside {4'd2, 4'd4, 4'd6, 4'd8}))
    else $error("ins_len %0d is not a legal instruction length", ins_len);

  // The source only strobes while room is high, so the sticky flag stays clear
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) !overflow)
    else $error("overflow went high, a fetch word was dropped");

  // A redirect suppresses the issue in its own cycle
  a_redirect_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    redirect |=> !ins_valid)
    else $error("ins_valid was high in the cycle after a redirect");

endmodule

bind thor_ifetch_top thor_ifetch_props props_i (
  .clk       (clk),
  .arst_n    (arst_n),
  .redirect  (redirect),
  .overflow  (overflow),
  .ins_valid (ins_valid),
  .ins_len   (ins_len)
);

//--- tb_thor_ifetch.sv
`timescale 1ns/1ns

// Random programs streamed through the aligner and checked against a byte-stream model
module tb_thor_ifetch import thor_pkg::*; ();

  localparam int    BUF_BYTES = 16;
  localparam addr_t RESET_PC  = 32'h0000_1000;
  localparam int    NUM_SEGS  = 6;

  logic        clk;
  logic        arst_n;
  logic        fetch_valid;
  fetch_word_t fetch_data;
  logic        room;
  logic        redirect;
  addr_t       redirect_pc;
  logic        overflow;
  logic        ins_valid;
  ins_t        ins;
  ilen_t       ins_len;
  addr_t       ins_pc;

  // Expected instructions of the current stream, oldest first
  ins_t  exp_ins [$];
  ilen_t exp_len [$];
  addr_t exp_pc [$];
  byte_t seg_bytes [$];
  int    seg_words [NUM_SEGS];
  int    seg_tail;
  int    pushed = 0;
  int    consumed = 0;
  int    cycles = 0;
  int    limit = 0;
  logic  send_ok = 1'b1;
  logic  after_redirect = 1'b0;
  logic  have_prev = 1'b0;
  addr_t prev_pc;
  ilen_t prev_len;

  tb_clkgen clkgen_i (.clk(clk), .arst_n(arst_n));

  thor_ifetch_top #(.BUF_BYTES(BUF_BYTES), .RESET_PC(RESET_PC)) dut_i (.*);

  // ==============================
  // Reference rules
  // ==============================

  // Instruction length in bytes from the opcode table
  function automatic int ref_len(byte_t op);
    if (op[7:4] == 4'hD) return 6;
    case (op)
      8'h02, 8'h05, 8'h20, 8'h54, 8'h55, 8'h60, 8'h70: return 6;
      8'h04, 8'h22, 8'h52, 8'h53, 8'h68, 8'hF4:        return 4;
      8'h56, 8'h57, 8'h58:                            return 8;
      default:                                        return 2;
    endcase
  endfunction

  // Opcode pool leans on the long forms and one pick in ten is any byte at all
  function automatic byte_t pick_opcode();
    byte_t pool [20];
    byte_t op;
    pool = '{8'h00, 8'h02, 8'h04, 8'h05, 8'h20, 8'h22, 8'h50, 8'h52, 8'h54, 8'h56,
             8'h56, 8'h58, 8'h58, 8'h60, 8'h68, 8'h70, 8'hD0, 8'hF1, 8'hF2, 8'hF4};
    op = pool[$urandom_range(0, 19)];
    // Pick either member of an EXI pair and any column of the D row
    if (op[7:4] == 4'h5 && op != 8'h58) op[0] = 1'($urandom);
    if (op == 8'hD0) op[3:0] = 4'($urandom);
    if ($urandom_range(0, 9) == 0) op = byte_t'($urandom);
    return op;
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      abort_run("The DUT disagrees with the model");
    end
  endtask

  // Build the byte stream of one segment; only whole instructions are expected
  task automatic build_segment(addr_t pc, int nbytes);
    byte_t op;
    int    len;
    ins_t  win;
    seg_bytes.delete();
    seg_tail = 0;
    while (seg_bytes.size() < nbytes) begin
      op       = pick_opcode();
      len      = ref_len(op);
      win      = '0;
      win[7:0] = op;
      for (int b = 1; b < len; b++) win[b*8 +: 8] = byte_t'($urandom);
      for (int b = 0; b < len; b++) seg_bytes.push_back(win[b*8 +: 8]);
      if (seg_bytes.size() <= nbytes) begin
        exp_ins.push_back(win);
        exp_len.push_back(ilen_t'(len));
        exp_pc.push_back(pc);
      end else begin
        seg_tail = nbytes - (seg_bytes.size() - len);
      end
      pc = pc + addr_t'(len);
    end
  endtask

  // ==============================
  // Monitor and model update
  // ==============================

  task automatic check_issue();
    ins_t  mask;
    ins_t  e_ins;
    ilen_t e_len;
    addr_t e_pc;
    if (exp_len.size() == 0) begin
      abort_run("An instruction was issued that the model does not expect");
    end else begin
      e_ins = exp_ins.pop_front();
      e_len = exp_len.pop_front();
      e_pc  = exp_pc.pop_front();
      mask  = '0;
      for (int b = 0; b < int'(e_len); b++) mask[b*8 +: 8] = 8'hff;
      check_val("ins_len", ins_len, e_len);
      check_val("ins_len of opcode", ins_len, ref_len(ins[7:0]));
      check_val("ins", ins & mask, e_ins & mask);
      check_val("ins_pc", ins_pc, e_pc);
      if (have_prev) check_val("ins_pc step", ins_pc, prev_pc + addr_t'(prev_len));
      prev_pc   = ins_pc;
      prev_len  = ins_len;
      have_prev = 1'b1;
      consumed  = consumed + int'(e_len);
    end
  endtask

  // Outputs are sampled mid cycle where they are stable
  always @(negedge clk) begin
    if (arst_n) begin
      check_val("overflow", overflow, 1'b0);
      if (after_redirect) check_val("ins_valid after redirect", ins_valid, 1'b0);
      after_redirect = redirect;
      if (ins_valid) check_issue();
      // Buffer fill is bytes accepted minus bytes issued
      check_val("room", room, (pushed - consumed) <= BUF_BYTES - FETCH_BYTES);
      if (redirect) begin
        pushed    = 0;
        consumed  = 0;
        have_prev = 1'b0;
      end else if (fetch_valid) begin
        pushed = pushed + FETCH_BYTES;
      end
      // Worst case fill next cycle, counting the word now in flight
      send_ok = (pushed - consumed) <= BUF_BYTES - FETCH_BYTES;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) abort_run("Timeout reached, the aligner stalled");
  end

  // ==============================
  // Stimulus
  // ==============================

  task automatic send_words(int nwords);
    fetch_word_t word;
    int          w;
    w = 0;
    while (w < nwords) begin
      @(posedge clk);
      if (send_ok && $urandom_range(0, 3) != 0) begin
        for (int b = 0; b < FETCH_BYTES; b++) word[b*8 +: 8] = seg_bytes[w*FETCH_BYTES + b];
        fetch_valid <= 1'b1;
        fetch_data  <= word;
        w++;
      end else begin
        fetch_valid <= 1'b0;
      end
    end
    @(posedge clk);
    fetch_valid <= 1'b0;
  endtask

  // Wait for every whole instruction, then only the cut one may stay buffered
  task automatic drain_segment();
    while (exp_len.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_val("count", dut_i.count, seg_tail);
  endtask

  initial begin
    addr_t pc;
    int    total;
    fetch_valid = 1'b0;
    fetch_data  = '0;
    redirect    = 1'b0;
    redirect_pc = '0;
    void'($urandom(32'h3dbd));
    total = 0;
    for (int s = 0; s < NUM_SEGS; s++) begin
      seg_words[s] = $urandom_range(4, 15);
      total        = total + seg_words[s];
    end
    limit = 4 * total + 200;
    build_segment(RESET_PC, seg_words[0] * FETCH_BYTES);
    @(posedge arst_n);
    @(negedge clk);
    check_val("ins_valid", ins_valid, 1'b0);
    check_val("overflow", overflow, 1'b0);
    check_val("room", room, 1'b1);
    for (int s = 0; s < NUM_SEGS; s++) begin
      if (s > 0) begin
        pc = $urandom & ~32'h1;
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= pc;
        // A word strobed together with the redirect is dropped
        fetch_valid <= 1'($urandom);
        fetch_data  <= {$urandom, $urandom};
        @(posedge clk);
        redirect    <= 1'b0;
        fetch_valid <= 1'b0;
        // Instructions of the old stream still waiting were flushed with their bytes
        @(negedge clk);
        exp_ins.delete();
        exp_len.delete();
        exp_pc.delete();
        build_segment(pc, seg_words[s] * FETCH_BYTES);
      end
      send_words(seg_words[s]);
      // Some segments are cut short by the next redirect while instructions still wait
      if (s == NUM_SEGS - 1 || $urandom_range(0, 1) == 0) drain_segment();
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- sim.f
thor_pkg.sv
thor_inslength.sv
thor_fetch_buffer.sv
thor_ins_align.sv
thor_ifetch_top.sv
tb_clkgen.sv
thor_ifetch_props.sv
tb_thor_ifetch.sv
